// File: hdl/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// width of a data word on the CPU side and on the bus.
`define MEM_DATA_W 32

// width of a byte address.
`define MEM_ADDR_W 32

// the RAM holds 2**RAM_WORDS_LOG2 words.
`define RAM_WORDS_LOG2 8

// cycles the RAM keeps stall high after a new strobe shows up.
`define RAM_STALL_CYCLES 1

// cycles from the taking cycle to ack. Must be 1 or more.
`define RAM_ACK_CYCLES 2

`endif

// File: hdl/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

    typedef logic [`MEM_DATA_W-1:0] word_t;  // one data word.
    typedef logic [`MEM_ADDR_W-1:0] addr_t;  // byte address.

    // kind of access the core asks for.
    typedef enum logic [1:0] {
        INST_READ  = 2'd0,
        DATA_READ  = 2'd1,
        DATA_WRITE = 2'd2
    } mem_op_e;

    // access size, as in the RV32 load and store encodings.
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // UNSIGNED matches funct3 bit 2 of LBU and LHU.
    typedef enum logic {
        SIGNED   = 1'b0,
        UNSIGNED = 1'b1
    } mem_sign_e;

    // one CPU access as the first stage captured it.
    typedef struct packed {
        mem_op_e   op;
        mem_size_e size;
        mem_sign_e sign;
        addr_t     addr;
        word_t     wdata;
    } mem_req_t;

endpackage

// File: hdl/wb_pkg.sv
`include "mem_params.svh"

package wb_pkg;

    // one bit per byte lane of the data bus.
    typedef logic [`MEM_DATA_W/8-1:0] wb_sel_t;

    // everything the master presents with stb, except cyc and stb themselves.
    typedef struct packed {
        logic                   we;
        wb_sel_t                sel;
        logic [`MEM_ADDR_W-1:0] adr;
        logic [`MEM_DATA_W-1:0] dat;
    } wb_req_t;

    // slave answer. dat is only meaningful while ack is high.
    typedef struct packed {
        logic                   stall;
        logic                   ack;
        logic [`MEM_DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

// File: hdl/mem_req_format.sv
module mem_req_format (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               mem_request_i,
    input  logic               accept_i,
    input  mem_pkg::mem_op_e   mem_op_i,
    input  mem_pkg::mem_size_e mem_size_i,
    input  mem_pkg::mem_sign_e mem_sign_i,
    input  mem_pkg::addr_t     mem_addr_i,
    input  mem_pkg::word_t     mem_wdata_i,
    output mem_pkg::mem_req_t  stage_req_o,
    output wb_pkg::wb_req_t    bus_req_o
);

    logic [1:0]      offset;
    logic            take;
    logic            we;
    wb_pkg::wb_sel_t sel;
    mem_pkg::word_t  wdata_lanes;

    assign offset = mem_addr_i[1:0];
    assign take   = mem_request_i && accept_i;  // the master leaves IDLE on the same edge.

    assign we = (mem_op_i == mem_pkg::DATA_WRITE);

    // Lanes past byte 3 fall off the shift, so a halfword at offset 3 only keeps lane 3.
    always_comb begin
        if (mem_op_i == mem_pkg::INST_READ) begin
            sel = 4'b1111;
        end else begin
            case (mem_size_i)
                mem_pkg::BYTE: sel = 4'b0001 << offset;
                mem_pkg::HALF: sel = 4'b0011 << offset;
                mem_pkg::WORD: sel = 4'b1111;
                default:       sel = 4'b0000;
            endcase
        end
    end

    // store data moves to the lanes it is written through.
    always_comb begin
        case (mem_size_i)
            mem_pkg::BYTE: wdata_lanes = mem_wdata_i << {offset, 3'b000};
            mem_pkg::HALF: wdata_lanes = mem_wdata_i << {offset[1], 4'b0000};  // halfword index.
            default:       wdata_lanes = mem_wdata_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_req_o <= '0;
            bus_req_o   <= '0;
        end else if (take) begin
            stage_req_o.op    <= mem_op_i;
            stage_req_o.size  <= mem_size_i;
            stage_req_o.sign  <= mem_sign_i;
            stage_req_o.addr  <= mem_addr_i;
            stage_req_o.wdata <= mem_wdata_i;
            bus_req_o.we      <= we;
            bus_req_o.sel     <= sel;
            bus_req_o.adr     <= mem_addr_i;  // byte address, the slave drops the low bits.
            bus_req_o.dat     <= wdata_lanes;
        end
    end

endmodule

// File: hdl/wb_master_fsm.sv
module wb_master_fsm (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            mem_request_i,
    output logic            idle_o,
    output logic            mem_done_o,
    input  wb_pkg::wb_req_t bus_req_i,
    input  wb_pkg::wb_rsp_t wb_rsp_i,
    output logic            wb_cyc_o,
    output logic            wb_stb_o,
    output wb_pkg::wb_req_t wb_req_o
);

    // IDLE waits for the core, REQUEST holds stb until the slave takes it,
    // WAIT4ACK holds the cycle open, DONE answers the core for one cycle.
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT4ACK,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   taken;

    // a strobe is taken in any REQUEST cycle without stall.
    assign taken = (state_q == REQUEST) && !wb_rsp_i.stall;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (mem_request_i) begin
                    state_d = REQUEST;
                end
            end
            REQUEST: begin
                if (taken && wb_rsp_i.ack) begin
                    state_d = DONE;  // slave answered in the taking cycle.
                end else if (taken) begin
                    state_d = WAIT4ACK;
                end
            end
            WAIT4ACK: begin
                if (wb_rsp_i.ack) begin
                    state_d = DONE;
                end
            end
            DONE:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_comb begin
        wb_cyc_o   = 1'b0;
        wb_stb_o   = 1'b0;
        mem_done_o = 1'b0;
        case (state_q)
            REQUEST: begin
                wb_cyc_o = 1'b1;
                wb_stb_o = 1'b1;
            end
            WAIT4ACK: wb_cyc_o = 1'b1;
            DONE:     mem_done_o = 1'b1;
            default: begin
                wb_cyc_o   = 1'b0;
                wb_stb_o   = 1'b0;
                mem_done_o = 1'b0;
            end
        endcase
    end

    assign idle_o = (state_q == IDLE);

    // the formatter keeps its register stable until the next accepted request.
    assign wb_req_o = bus_req_i;

endmodule

// File: hdl/mem_load_align.sv
module mem_load_align (
    input  logic              clk_i,
    input  logic              rst_i,
    input  mem_pkg::mem_req_t stage_req_i,
    input  wb_pkg::wb_rsp_t   wb_rsp_i,
    output mem_pkg::word_t    instruction_o,
    output mem_pkg::word_t    data_o
);

    logic [1:0]     offset;
    logic           sign_ext;
    logic [7:0]     lane_byte;
    logic [15:0]    lane_half;
    logic           fill_byte;
    logic           fill_half;
    mem_pkg::word_t load_word;

    assign offset   = stage_req_i.addr[1:0];
    assign sign_ext = (stage_req_i.sign == mem_pkg::SIGNED);

    // same lane rule as the store side.
    assign lane_byte = wb_rsp_i.dat[{offset, 3'b000} +: 8];
    assign lane_half = wb_rsp_i.dat[{offset[1], 4'b0000} +: 16];

    assign fill_byte = sign_ext && lane_byte[7];
    assign fill_half = sign_ext && lane_half[15];

    always_comb begin
        case (stage_req_i.size)
            mem_pkg::BYTE: load_word = {{24{fill_byte}}, lane_byte};
            mem_pkg::HALF: load_word = {{16{fill_half}}, lane_half};
            default:       load_word = wb_rsp_i.dat;
        endcase
    end

    // Fetches keep the whole word. The new value shows up together with done.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instruction_o <= '0;
        end else if (wb_rsp_i.ack && (stage_req_i.op == mem_pkg::INST_READ)) begin
            instruction_o <= wb_rsp_i.dat;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_o <= '0;
        end else if (wb_rsp_i.ack && (stage_req_i.op == mem_pkg::DATA_READ)) begin
            data_o <= load_word;  // stores leave it alone.
        end
    end

endmodule

// File: hdl/wb_ram.sv
`include "mem_params.svh"

module wb_ram #(
    parameter int unsigned STALL_CYCLES = `RAM_STALL_CYCLES,
    parameter int unsigned ACK_CYCLES   = `RAM_ACK_CYCLES
) (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            wb_cyc_i,
    input  logic            wb_stb_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o
);

    localparam int unsigned WORDS   = 2 ** `RAM_WORDS_LOG2;
    localparam int unsigned LANES   = `MEM_DATA_W / 8;
    localparam int unsigned STALL_W = $clog2(STALL_CYCLES + 2);
    localparam int unsigned DLY_W   = $clog2(ACK_CYCLES + 1);

    typedef logic [`RAM_WORDS_LOG2-1:0] ram_idx_t;

    logic [`MEM_DATA_W-1:0] mem_q [WORDS];

    logic [STALL_W-1:0]     stall_cnt_q;
    logic [DLY_W-1:0]       dly_q;
    logic                   busy_q;  // a strobe was taken and its ack is still due.
    logic                   pend_we_q;
    wb_pkg::wb_sel_t        pend_sel_q;
    ram_idx_t               pend_idx_q;
    logic [`MEM_DATA_W-1:0] pend_dat_q;

    logic strobe;
    logic stall;
    logic take;
    logic ack;

    assign strobe = wb_cyc_i && wb_stb_i;
    assign stall  = busy_q || (stall_cnt_q < STALL_W'(STALL_CYCLES));
    assign take   = strobe && !stall;
    assign ack    = busy_q && (dly_q == '0);

    // counts how long the current strobe has been held off.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stall_cnt_q <= '0;
        end else if (!strobe || take) begin
            stall_cnt_q <= '0;
        end else if (!busy_q && stall) begin
            stall_cnt_q <= stall_cnt_q + 1'b1;
        end
    end

    // ack lands ACK_CYCLES after the taking cycle. Dropping cyc abandons it.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
            dly_q  <= '0;
        end else if (take) begin
            busy_q <= 1'b1;
            dly_q  <= DLY_W'(ACK_CYCLES - 1);
        end else if (ack || !wb_cyc_i) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            dly_q <= dly_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            pend_we_q  <= wb_req_i.we;
            pend_sel_q <= wb_req_i.sel;
            pend_idx_q <= wb_req_i.adr[`RAM_WORDS_LOG2+1:2];  // word address.
            pend_dat_q <= wb_req_i.dat;
        end
    end

    // writes merge only the selected lanes, in the ack cycle.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (ack && pend_we_q) begin
            for (int b = 0; b < LANES; b++) begin
                if (pend_sel_q[b]) begin
                    mem_q[pend_idx_q][8*b +: 8] <= pend_dat_q[8*b +: 8];
                end
            end
        end
    end

    // Reads always return the full word and leave lane picking to the master side.
    assign wb_rsp_o = '{
        stall: stall,
        ack:   ack,
        dat:   ack ? mem_q[pend_idx_q] : '0
    };

endmodule

// File: hdl/mem_subsys_top.sv
module mem_subsys_top (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               mem_request_i,
    input  mem_pkg::mem_op_e   mem_op_i,
    input  mem_pkg::mem_sign_e mem_sign_i,
    input  mem_pkg::mem_size_e mem_size_i,
    input  mem_pkg::addr_t     mem_addr_i,
    input  mem_pkg::word_t     mem_wdata_i,
    output logic               mem_done_o,
    output mem_pkg::word_t     instruction_o,
    output mem_pkg::word_t     data_o
);

    logic              idle;
    mem_pkg::mem_req_t stage_req;
    wb_pkg::wb_req_t   bus_req;
    logic              wb_cyc;
    logic              wb_stb;
    wb_pkg::wb_req_t   wb_req;
    wb_pkg::wb_rsp_t   wb_rsp;

    mem_req_format mem_req_format_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_request_i (mem_request_i),
        .accept_i      (idle),
        .mem_op_i      (mem_op_i),
        .mem_size_i    (mem_size_i),
        .mem_sign_i    (mem_sign_i),
        .mem_addr_i    (mem_addr_i),
        .mem_wdata_i   (mem_wdata_i),
        .stage_req_o   (stage_req),
        .bus_req_o     (bus_req)
    );

    wb_master_fsm wb_master_fsm_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_request_i (mem_request_i),
        .idle_o        (idle),
        .mem_done_o    (mem_done_o),
        .bus_req_i     (bus_req),
        .wb_rsp_i      (wb_rsp),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_req_o      (wb_req)
    );

    mem_load_align mem_load_align_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stage_req_i   (stage_req),
        .wb_rsp_i      (wb_rsp),
        .instruction_o (instruction_o),
        .data_o        (data_o)
    );

    wb_ram wb_ram_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

endmodule

// File: tb/mem_subsys_tb.sv
`include "mem_params.svh"

module mem_subsys_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_ACCESSES = 360;  // directed tests plus the random run.
    localparam int WORST_CYCLES = 10;
    localparam int WATCHDOG_NS  = (NUM_ACCESSES * WORST_CYCLES + 10 + 200) * CLK_PERIOD;
    localparam int RAM_WORDS    = 2 ** `RAM_WORDS_LOG2;

    logic               clk_i;
    logic               rst_i;
    logic               mem_request_i;
    mem_pkg::mem_op_e   mem_op_i;
    mem_pkg::mem_sign_e mem_sign_i;
    mem_pkg::mem_size_e mem_size_i;
    mem_pkg::addr_t     mem_addr_i;
    mem_pkg::word_t     mem_wdata_i;
    logic               mem_done_o;
    mem_pkg::word_t     instruction_o;
    mem_pkg::word_t     data_o;

    mem_pkg::word_t shadow [RAM_WORDS];  // RAM contents as the testbench expects them.
    mem_pkg::word_t exp_instr;
    mem_pkg::word_t exp_data;
    int             done_count;
    int             accesses_done;  // requests that have run to completion.

    mem_subsys_top mem_subsys_top_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_request_i (mem_request_i),
        .mem_op_i      (mem_op_i),
        .mem_sign_i    (mem_sign_i),
        .mem_size_i    (mem_size_i),
        .mem_addr_i    (mem_addr_i),
        .mem_wdata_i   (mem_wdata_i),
        .mem_done_o    (mem_done_o),
        .instruction_o (instruction_o),
        .data_o        (data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error.");
    endtask

    // Expected RAM word after a store, or expected register value after a load or fetch.
    function automatic mem_pkg::word_t expected_result(
        input mem_pkg::mem_op_e   op,
        input mem_pkg::mem_size_e size,
        input mem_pkg::mem_sign_e sign,
        input mem_pkg::addr_t     addr,
        input mem_pkg::word_t     wdata,
        input mem_pkg::word_t     old_word
    );
        int unsigned    byte_pos;
        int unsigned    half_pos;
        logic [7:0]     b;
        logic [15:0]    h;
        mem_pkg::word_t result;
        byte_pos = addr[1:0];
        half_pos = addr[1];  // halfword index inside the word.
        b        = old_word[8*byte_pos +: 8];
        h        = old_word[16*half_pos +: 16];
        result   = old_word;
        if (op == mem_pkg::DATA_WRITE) begin
            case (size)
                mem_pkg::BYTE: result[8*byte_pos +: 8] = wdata[7:0];
                mem_pkg::HALF: result[16*half_pos +: 16] = wdata[15:0];
                default:       result = wdata;
            endcase
        end else if (op == mem_pkg::DATA_READ) begin
            case (size)
                mem_pkg::BYTE: result = (sign == mem_pkg::SIGNED && b[7]) ?
                                        {24'hFF_FFFF, b} : {24'h00_0000, b};
                mem_pkg::HALF: result = (sign == mem_pkg::SIGNED && h[15]) ?
                                        {16'hFFFF, h} : {16'h0000, h};
                default:       result = old_word;
            endcase
        end
        return result;  // a fetch gets the whole word.
    endfunction

    // Issues one access a little after a rising edge and waits for its done pulse.
    task automatic access(
        input mem_pkg::mem_op_e   op,
        input mem_pkg::mem_size_e size,
        input mem_pkg::mem_sign_e sign,
        input mem_pkg::addr_t     addr,
        input mem_pkg::word_t     wdata
    );
        int unsigned idx;
        idx = addr[`RAM_WORDS_LOG2+1:2];
        case (op)
            mem_pkg::DATA_WRITE: shadow[idx] = expected_result(op, size, sign, addr, wdata,
                                                               shadow[idx]);
            mem_pkg::DATA_READ:  exp_data = expected_result(op, size, sign, addr, wdata,
                                                            shadow[idx]);
            default:             exp_instr = expected_result(op, size, sign, addr, wdata,
                                                             shadow[idx]);
        endcase
        mem_request_i = 1'b1;
        mem_op_i      = op;
        mem_size_i    = size;
        mem_sign_i    = sign;
        mem_addr_i    = addr;
        mem_wdata_i   = wdata;
        @(posedge clk_i);
        #2;
        mem_request_i = 1'b0;  // inputs stay put until done.
        do begin
            @(negedge clk_i);
        end while (!mem_done_o);
        @(posedge clk_i);
        #2;
        accesses_done++;
        // done must already be low again, and no pulse may have come outside an access.
        assert (done_count == accesses_done && !mem_done_o) else
            stop_on_error($sformatf("access to %08h: %0d done pulses for %0d requests, done %0b",
                                    addr, done_count, accesses_done, mem_done_o));
    endtask

    task automatic random_accesses(input int count);
        mem_pkg::mem_op_e   op;
        mem_pkg::mem_size_e size;
        mem_pkg::mem_sign_e sign;
        int unsigned        offset;
        mem_pkg::addr_t     addr;
        for (int n = 0; n < count; n++) begin
            case ($urandom_range(2, 0))
                0:       op = mem_pkg::INST_READ;
                1:       op = mem_pkg::DATA_READ;
                default: op = mem_pkg::DATA_WRITE;
            endcase
            case ($urandom_range(2, 0))
                0:       size = mem_pkg::BYTE;
                1:       size = mem_pkg::HALF;
                default: size = mem_pkg::WORD;
            endcase
            sign = ($urandom_range(1, 0) == 0) ? mem_pkg::SIGNED : mem_pkg::UNSIGNED;
            if (op == mem_pkg::INST_READ) begin
                size = mem_pkg::WORD;
            end
            case (size)
                mem_pkg::BYTE: offset = $urandom_range(3, 0);
                mem_pkg::HALF: offset = 2 * $urandom_range(1, 0);
                default:       offset = 0;
            endcase
            addr = 32'h0000_0200 + 4 * $urandom_range(15, 0) + offset;
            access(op, size, sign, addr, $urandom);
        end
    endtask

    // every done pulse is counted, and both registers are compared with the reference.
    always @(negedge clk_i) begin
        if (!rst_i && mem_done_o) begin
            done_count++;
            assert (instruction_o == exp_instr) else
                stop_on_error($sformatf("instruction_o is %08h, expected %08h",
                                        instruction_o, exp_instr));
            assert (data_o == exp_data) else
                stop_on_error($sformatf("data_o is %08h, expected %08h", data_o, exp_data));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: the accesses did not complete within %0d ns.", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired.");
    end

    initial begin
        mem_pkg::word_t pattern [2];
        void'($urandom(80238));
        rst_i         = 1'b1;
        mem_request_i = 1'b0;
        mem_op_i      = mem_pkg::INST_READ;
        mem_size_i    = mem_pkg::WORD;
        mem_sign_i    = mem_pkg::SIGNED;
        mem_addr_i    = '0;
        mem_wdata_i   = '0;
        exp_instr     = '0;
        exp_data      = '0;
        done_count    = 0;
        accesses_done = 0;
        pattern[0]    = 32'hF0A5_8C91;  // every byte has its top bit set.
        pattern[1]    = 32'h7F35_0C61;  // every byte has its top bit clear.
        for (int i = 0; i < RAM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        // the idle unit keeps both registers at zero and never signals done.
        repeat (5) @(negedge clk_i);
        assert (instruction_o == '0 && data_o == '0 && done_count == 0) else
            stop_on_error($sformatf("after reset instr %08h data %08h done pulses %0d",
                                    instruction_o, data_o, done_count));
        @(posedge clk_i);
        #2;

        for (int i = 0; i < 4; i++) begin
            access(mem_pkg::DATA_WRITE, mem_pkg::WORD, mem_pkg::SIGNED, 32'h10 + 4 * i, $urandom);
        end
        // fetches walk the words backwards, so a load and the fetch after it see different words.
        for (int i = 0; i < 4; i++) begin
            access(mem_pkg::DATA_READ, mem_pkg::WORD, mem_pkg::SIGNED, 32'h10 + 4 * i, '0);
            access(mem_pkg::INST_READ, mem_pkg::WORD, mem_pkg::SIGNED, 32'h1C - 4 * i, '0);
        end

        // narrow stores merge into a known word.
        for (int off = 0; off < 4; off++) begin
            access(mem_pkg::DATA_WRITE, mem_pkg::WORD, mem_pkg::SIGNED, 32'h40, 32'h1122_3344);
            access(mem_pkg::DATA_WRITE, mem_pkg::BYTE, mem_pkg::SIGNED, 32'h40 + off,
                   32'hA5A5_A5C0 + off);
            access(mem_pkg::DATA_READ, mem_pkg::WORD, mem_pkg::SIGNED, 32'h40, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            access(mem_pkg::DATA_WRITE, mem_pkg::WORD, mem_pkg::SIGNED, 32'h44, 32'hDEAD_BEEF);
            access(mem_pkg::DATA_WRITE, mem_pkg::HALF, mem_pkg::SIGNED, 32'h44 + off,
                   32'hFFFF_1234 + off);
            access(mem_pkg::DATA_READ, mem_pkg::WORD, mem_pkg::SIGNED, 32'h44, '0);
        end

        for (int p = 0; p < 2; p++) begin
            access(mem_pkg::DATA_WRITE, mem_pkg::WORD, mem_pkg::SIGNED, 32'h80, pattern[p]);
            for (int off = 0; off < 4; off++) begin
                access(mem_pkg::DATA_READ, mem_pkg::BYTE, mem_pkg::SIGNED, 32'h80 + off, '0);
                access(mem_pkg::DATA_READ, mem_pkg::BYTE, mem_pkg::UNSIGNED, 32'h80 + off, '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                access(mem_pkg::DATA_READ, mem_pkg::HALF, mem_pkg::SIGNED, 32'h80 + off, '0);
                access(mem_pkg::DATA_READ, mem_pkg::HALF, mem_pkg::UNSIGNED, 32'h80 + off, '0);
            end
        end

        // stores after a load must leave both registers alone.
        access(mem_pkg::DATA_READ, mem_pkg::WORD, mem_pkg::SIGNED, 32'h10, '0);
        access(mem_pkg::DATA_WRITE, mem_pkg::BYTE, mem_pkg::SIGNED, 32'h11, 32'h0000_005A);
        access(mem_pkg::DATA_WRITE, mem_pkg::HALF, mem_pkg::SIGNED, 32'h12, 32'h0000_C3C3);
        access(mem_pkg::DATA_WRITE, mem_pkg::WORD, mem_pkg::SIGNED, 32'h14, 32'h0BAD_F00D);

        random_accesses(300);

        // the unit stays quiet once the last request is answered.
        repeat (5) @(negedge clk_i);
        assert (done_count == accesses_done) else
            stop_on_error($sformatf("%0d done pulses for %0d requests",
                                    done_count, accesses_done));

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: mem_subsys.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/wb_pkg.sv
hdl/mem_req_format.sv
hdl/wb_master_fsm.sv
hdl/mem_load_align.sv
hdl/wb_ram.sv
hdl/mem_subsys_top.sv
tb/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_pkg.sv
      - hdl/wb_pkg.sv
      - hdl/mem_req_format.sv
      - hdl/wb_master_fsm.sv
      - hdl/mem_load_align.sv
      - hdl/wb_ram.sv
      - hdl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/mem_subsys_tb.sv
